/* verilog/router_defines.svh */
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// Flit format
`define FLIT_W 32
`define KIND_HI 31
`define KIND_LO 29

// Packet length in flits, head included, sits in the low bits of a head flit
`define LEN_W 12

// Local, North, East, West, South
`define NUM_PORTS 5

`endif

/* verilog/routerPkg.sv */
`default_nettype none

`include "router_defines.svh"

package routerPkg;

  // Arbiter state, one-hot with idle in bit 0
  typedef enum logic [`NUM_PORTS:0] {
    portIdle  = 6'b000001,
    portLocal = 6'b000010,
    portNorth = 6'b000100,
    portEast  = 6'b001000,
    portWest  = 6'b010000,
    portSouth = 6'b100000
  } portSel;

  typedef enum logic [`KIND_HI-`KIND_LO:0] {
    kindHead = 3'd1,
    kindBody = 3'd2
  } flitKind;

endpackage

`default_nettype wire

/* verilog/inputStage.sv */
`default_nettype none

`include "router_defines.svh"

module inputStage (
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  output logic               inReady,
  input  logic [`FLIT_W-1:0] inFlit,
  output logic               reqValid,
  output logic [`FLIT_W-1:0] heldFlit,
  input  logic               drain
);

  logic               full;
  logic               alive; // Low through reset so the lane refuses flits
  logic               loadNow;
  logic [`FLIT_W-1:0] slot;

  // Empty, or emptying this cycle, means room for one more
  assign inReady  = alive && (!full || drain);
  assign loadNow  = inValid && inReady;
  assign reqValid = full;
  assign heldFlit = slot;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full  <= 1'b0;
      alive <= 1'b0;
    end
    else
    begin
      alive <= 1'b1;
      if (loadNow)
        full <= 1'b1; // Reload wins over drain
      else if (drain)
        full <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (loadNow)
      slot <= inFlit;
  end

  // Crossbar must only drain the stage it is reading from
  drainWhenFull: assert property (@(posedge clk) disable iff (rst) drain |-> full)
    else $error("drain on empty input stage");

endmodule

`default_nettype wire

/* verilog/grantTimer.sv */
`default_nettype none

`include "router_defines.svh"

module grantTimer (
  input  logic              clk,
  input  logic              rst,
  input  logic              granted,
  input  logic              headTaken,
  input  logic              flitTaken,
  input  logic [`LEN_W-1:0] headLength,
  output logic              timesUp
);

  logic [`LEN_W-1:0] pktLen;
  logic [`LEN_W-1:0] flitCount;
  logic              loaded;

  always_ff @(posedge clk)
  begin
    if (rst || !granted)
    begin
      pktLen    <= '0;
      flitCount <= '0;
      loaded    <= 1'b0;
    end
    else if (headTaken)
    begin
      pktLen    <= headLength;
      flitCount <= `LEN_W'(1); // Head counts as the first flit
      loaded    <= 1'b1;
    end
    else if (flitTaken)
      flitCount <= flitCount + `LEN_W'(1);
  end

  assign timesUp = loaded && (flitCount == pktLen);

  // Arbiter must close the grant before the count runs past the length
  countInRange: assert property (@(posedge clk) disable iff (rst)
    loaded |-> (flitCount <= pktLen))
    else $error("flit count passed packet length");

endmodule

`default_nettype wire

/* verilog/packetArbiter.sv */
`default_nettype none

`include "router_defines.svh"

module packetArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  logic                  headTaken,
  input  logic                  flitTaken,
  input  logic [`LEN_W-1:0]     headLength,
  output routerPkg::portSel     grant,
  output logic                  grantOpen
);

  import routerPkg::*;

  portSel                state;
  portSel                nextState;
  logic [`NUM_PORTS-1:0] portGranted;
  logic [`NUM_PORTS-1:0] timesUp;
  logic                  holdGrant;
  int unsigned           curIdx;

  // First requester found when scanning from port index first, wrapping around
  function automatic portSel pickNext(input logic [`NUM_PORTS-1:0] reqs,
                                      input int unsigned first);
    portSel            pick;
    int unsigned       idx;
    logic [`NUM_PORTS:0] oneHot;
    pick = portIdle;
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = first + k;
      if (idx >= `NUM_PORTS)
        idx = idx - `NUM_PORTS;
      if (reqs[idx])
      begin
        oneHot = '0;
        oneHot[idx + 1] = 1'b1; // Bit 0 is idle
        pick = portSel'(oneHot);
      end
    end
    return pick;
  endfunction

  assign portGranted = state[`NUM_PORTS:1];

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : timerGen
    grantTimer uTimer (
      .clk        (clk),
      .rst        (rst),
      .granted    (portGranted[i] && holdGrant), // Cleared as a grant ends so a regrant starts fresh
      .headTaken  (headTaken && portGranted[i]),
      .flitTaken  (flitTaken && portGranted[i]),
      .headLength (headLength),
      .timesUp    (timesUp[i])
    );
  end

  always_comb
  begin
    curIdx = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (portGranted[i])
        curIdx = i;
    end
  end

  // Granted port still asking and packet not finished
  assign holdGrant = |(portGranted & req & ~timesUp);

  always_comb
  begin
    if (state == portIdle)
      nextState = pickNext(req, 0); // Local first out of idle
    else if (holdGrant)
      nextState = state;
    else
      nextState = pickNext(req, curIdx + 1);
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= portIdle;
    else
      state <= nextState;
  end

  assign grant = state;

  // Closed on the cycle the length is reached so the next packet waits
  assign grantOpen = (state != portIdle) && !(|(portGranted & timesUp));

  stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
    else $error("arbiter state not one-hot");

endmodule

`default_nettype wire

/* verilog/crossbarMux.sv */
`default_nettype none

`include "router_defines.svh"

module crossbarMux (
  input  routerPkg::portSel                   grant,
  input  logic                                grantOpen,
  input  logic [`NUM_PORTS-1:0]               reqValid,
  input  logic [`NUM_PORTS-1:0][`FLIT_W-1:0]  heldFlit,
  output logic                                outValid,
  input  logic                                outReady,
  output logic [`FLIT_W-1:0]                  outFlit,
  output logic [`NUM_PORTS-1:0]               drain,
  output logic                                flitTaken,
  output logic                                headTaken,
  output logic [`LEN_W-1:0]                   headLength
);

  import routerPkg::*;

  logic [`NUM_PORTS-1:0] sel;
  logic                  isHead;

  assign sel = grant[`NUM_PORTS:1]; // All zero when idle

  always_comb
  begin
    outFlit = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (sel[i])
        outFlit = heldFlit[i];
    end
  end

  assign outValid  = grantOpen && |(sel & reqValid);
  assign flitTaken = outValid && outReady;
  assign drain     = {`NUM_PORTS{flitTaken}} & sel;

  always_comb
  begin
    case (flitKind'(outFlit[`KIND_HI:`KIND_LO]))
      kindHead: isHead = 1'b1;
      kindBody: isHead = 1'b0;
      default:  isHead = 1'b0; // Unknown kinds pass as body
    endcase
  end

  assign headTaken  = flitTaken && isHead;
  assign headLength = outFlit[`LEN_W-1:0];

endmodule

`default_nettype wire

/* verilog/routerOutPort.sv */
`default_nettype none

`include "router_defines.svh"

module routerOutPort (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [`NUM_PORTS-1:0]               inValid,
  output logic [`NUM_PORTS-1:0]               inReady,
  input  logic [`NUM_PORTS-1:0][`FLIT_W-1:0]  inFlit,
  output logic                                outValid,
  input  logic                                outReady,
  output logic [`FLIT_W-1:0]                  outFlit,
  output routerPkg::portSel                   grant
);

  logic [`NUM_PORTS-1:0]              reqValid;
  logic [`NUM_PORTS-1:0]              drain;
  logic [`NUM_PORTS-1:0][`FLIT_W-1:0] heldFlit;
  logic                               grantOpen;
  logic                               flitTaken;
  logic                               headTaken;
  logic [`LEN_W-1:0]                  headLength;

  // Port order L, N, E, W, S on every vector
  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : stageGen
    inputStage uStage (
      .clk      (clk),
      .rst      (rst),
      .inValid  (inValid[i]),
      .inReady  (inReady[i]),
      .inFlit   (inFlit[i]),
      .reqValid (reqValid[i]),
      .heldFlit (heldFlit[i]),
      .drain    (drain[i])
    );
  end

  packetArbiter uArbiter (
    .clk        (clk),
    .rst        (rst),
    .req        (reqValid),
    .headTaken  (headTaken),
    .flitTaken  (flitTaken),
    .headLength (headLength),
    .grant      (grant),
    .grantOpen  (grantOpen)
  );

  crossbarMux uCrossbar (
    .grant      (grant),
    .grantOpen  (grantOpen),
    .reqValid   (reqValid),
    .heldFlit   (heldFlit),
    .outValid   (outValid),
    .outReady   (outReady),
    .outFlit    (outFlit),
    .drain      (drain),
    .flitTaken  (flitTaken),
    .headTaken  (headTaken),
    .headLength (headLength)
  );

endmodule

`default_nettype wire

/* verif/routerOutPort_tests.svh */
`ifndef ROUTEROUTPORT_TESTS_SVH
`define ROUTEROUTPORT_TESTS_SVH

task automatic expectPacket(input int port, input int pktId, input int len, input int count);
  expFlits.push_back(headFlit(port, pktId, len));
  expGrants.push_back(portGrant(port));
  for (int s = 1; s < count; s++)
  begin
    expFlits.push_back(bodyFlit(port, pktId, s));
    expGrants.push_back(portGrant(port));
  end
endtask

task automatic compareOutput(input string testName);
  while (gotFlits.size() < expFlits.size())
    @(negedge clk);
  repeat (4) @(negedge clk); // Duplicates would land here
  checkValue({testName, " flit count"}, gotFlits.size(), expFlits.size());
  foreach (expFlits[i])
  begin
    checkValue($sformatf("%s outFlit[%0d]", testName, i), gotFlits[i], expFlits[i]);
    checkValue($sformatf("%s grant[%0d]", testName, i), 32'(gotGrants[i]), 32'(expGrants[i]));
  end
  expFlits.delete();
  expGrants.delete();
  gotFlits.delete();
  gotGrants.delete();
endtask

task automatic resetValues();
  repeat (9) @(posedge clk);
  @(negedge clk);
  checkValue("outValid in reset", 32'(outValid), 32'h0);
  checkValue("inReady in reset", 32'(inReady), 32'h0);
  @(posedge clk);
  rst <= 1'b0;
  repeat (2) @(negedge clk);
  checkValue("outValid after reset", 32'(outValid), 32'h0);
  checkValue("inReady after reset", 32'(inReady), 32'h1f);
  checkValue("grant after reset", 32'(grant), 32'(portIdle));
endtask

// Lengths 1 to 5, one port at a time
task automatic singlePortPackets();
  for (int p = 0; p < `NUM_PORTS; p++)
  begin
    expectPacket(p, 16 + p, p + 1, p + 1);
    runPort(p, 16 + p, p + 1, 1);
    compareOutput("single port");
  end
endtask

task automatic allPortsRotation();
  for (int p = 0; p < `NUM_PORTS; p++)
    expectPacket(p, 32 + p, p + 2, p + 2);
  fork
    runPort(0, 32, 2, 1);
    runPort(1, 33, 3, 1);
    runPort(2, 34, 4, 1);
    runPort(3, 35, 5, 1);
    runPort(4, 36, 6, 1);
  join
  compareOutput("all ports");
endtask

// Local's second packet waits behind North and its third follows with no rival
task automatic backToBackPackets();
  expectPacket(0, 48, 3, 3);
  expectPacket(1, 52, 4, 4);
  expectPacket(0, 49, 3, 3);
  expectPacket(0, 50, 3, 3);
  fork
    runPort(0, 48, 3, 3);
    runPort(1, 52, 4, 1);
  join
  compareOutput("back to back");
endtask

task automatic randomBackpressure();
  logic [31:0] randBits;
  for (int r = 0; r < 2; r++)
    for (int p = 0; p < `NUM_PORTS; p++)
      expectPacket(p, 64 + 2 * p + r, 4, 4);
  fork
    runPort(0, 64, 4, 2);
    runPort(1, 66, 4, 2);
    runPort(2, 68, 4, 2);
    runPort(3, 70, 4, 2);
    runPort(4, 72, 4, 2);
    begin
      while (gotFlits.size() < expFlits.size())
      begin
        @(posedge clk);
        randBits = $random(seed);
        outReady <= randBits[0];
      end
      @(posedge clk);
      outReady <= 1'b1;
    end
  join
  compareOutput("random backpressure");
endtask

// Local stops after two of six flits
task automatic requestDropHandoff();
  expectPacket(0, 80, 6, 2);
  expectPacket(1, 81, 4, 4);
  fork
    begin
      @(posedge clk);
      sendPacket(0, 80, 6, 2);
      inValid[0] <= 1'b0;
    end
    runPort(1, 81, 4, 1);
  join
  compareOutput("request drop");
endtask

`endif

/* verif/routerOutPort_tb.sv */
`default_nettype none

`include "router_defines.svh"

module routerOutPort_tb;

  import routerPkg::*;

  localparam int CLK_PERIOD      = 8;
  localparam int TEST_FLITS      = 15 + 20 + 13 + 40 + 6; // All flits over all tests
  localparam int WATCHDOG_CYCLES = 20 + 8 * TEST_FLITS;   // Room for back-pressure and gaps

  logic                               clk = 1'b0;
  logic                               rst;
  logic [`NUM_PORTS-1:0]              inValid;
  logic [`NUM_PORTS-1:0]              inReady;
  logic [`NUM_PORTS-1:0][`FLIT_W-1:0] inFlit;
  logic                               outValid;
  logic                               outReady;
  logic [`FLIT_W-1:0]                 outFlit;
  portSel                             grant;

  integer             seed;
  logic [`FLIT_W-1:0] expFlits[$];
  portSel             expGrants[$];
  logic [`FLIT_W-1:0] gotFlits[$];
  portSel             gotGrants[$];

  always #(CLK_PERIOD / 2) clk = ~clk;

  routerOutPort i_dut (
    .clk      (clk),
    .rst      (rst),
    .inValid  (inValid),
    .inReady  (inReady),
    .inFlit   (inFlit),
    .outValid (outValid),
    .outReady (outReady),
    .outFlit  (outFlit),
    .grant    (grant)
  );

  // Output monitor, sampled mid-cycle
  always @(negedge clk)
  begin
    if (!rst && outValid && outReady)
    begin
      gotFlits.push_back(outFlit);
      gotGrants.push_back(grant);
    end
  end

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  // Test flits carry kind, source port, packet id, then length or sequence number
  function automatic logic [`FLIT_W-1:0] headFlit(input int port, input int pktId, input int len);
    return {3'd1, 3'(port), 8'(pktId), 6'd0, `LEN_W'(len)};
  endfunction

  function automatic logic [`FLIT_W-1:0] bodyFlit(input int port, input int pktId, input int seq);
    return {3'd2, 3'(port), 8'(pktId), 18'(seq)};
  endfunction

  function automatic portSel portGrant(input int port);
    portSel sel;
    case (port)
      0:       sel = portLocal;
      1:       sel = portNorth;
      2:       sel = portEast;
      3:       sel = portWest;
      default: sel = portSouth;
    endcase
    return sel;
  endfunction

  // Called on a rising edge, returns on the edge where the flit is taken
  task automatic sendFlit(input int port, input logic [`FLIT_W-1:0] flit);
    inValid[port] <= 1'b1;
    inFlit[port]  <= flit;
    @(negedge clk);
    while (!inReady[port])
      @(negedge clk);
    @(posedge clk);
  endtask

  // Head plus count-1 body flits; count below len leaves the packet cut short
  task automatic sendPacket(input int port, input int pktId, input int len, input int count);
    sendFlit(port, headFlit(port, pktId, len));
    for (int s = 1; s < count; s++)
      sendFlit(port, bodyFlit(port, pktId, s));
  endtask

  // Back to back packets with ids pktId, pktId+1, ...
  task automatic runPort(input int port, input int pktId, input int len, input int numPkts);
    @(posedge clk);
    for (int k = 0; k < numPkts; k++)
      sendPacket(port, pktId + k, len, len);
    inValid[port] <= 1'b0;
  endtask

  `include "routerOutPort_tests.svh"

  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, output stopped moving", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  initial
  begin
    seed     = 32'hfc23_64d0;
    rst      = 1'b1;
    inValid  = '0;
    inFlit   = '0;
    outReady = 1'b1;
    resetValues();
    singlePortPackets();
    allPortsRotation();
    backToBackPackets();
    randomBackpressure();
    requestDropHandoff();
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
+incdir+verif
verilog/routerPkg.sv
verilog/inputStage.sv
verilog/grantTimer.sv
verilog/packetArbiter.sv
verilog/crossbarMux.sv
verilog/routerOutPort.sv
verif/routerOutPort_tb.sv

/* Makefile */
# Verilator build and run of the router output port testbench
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= routerOutPort_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "Simulation did not finish"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
